/* vlog.f */
+incdir+design
design/axi_bridge_pkg.sv
design/axi_rd_master.sv
design/axi_wr_master.sv
design/axi_bridge_top.sv
tests/tb_clk_gen.sv
tests/axi_mem_model.sv
tests/axi_bridge_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = axi_bridge_tb
FILELIST = vlog.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

/* tests/axi_bridge_tb.sv */
`include "axi_defines.svh"

module axi_bridge_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int         TIMEOUT = 200;
	localparam logic [3:0] RD_ID   = 4'h3;
	localparam logic [3:0] WR_ID   = 4'h5;

	typedef struct packed {
		logic             is_write;
		logic [63:0]      addr;
		logic [1:0]       size;
		logic [7:0]       len;
		logic [63:0]      wdata;
		logic [3:0][63:0] exp_data; // one entry per beat up to len 3
		logic [1:0]       exp_resp;
	} row_t;

	logic                        clk;
	logic                        reset_n;
	logic                        delay_en;
	logic                        rd_req_valid;
	axi_bridge_pkg::cpu_rd_req_t rd_req;
	logic                        rd_req_ready;
	logic                        rd_rsp_valid;
	axi_bridge_pkg::cpu_rd_rsp_t rd_rsp;
	logic                        wr_req_valid;
	axi_bridge_pkg::cpu_wr_req_t wr_req;
	logic                        wr_req_ready;
	logic                        wr_done;
	axi_bridge_pkg::cpu_wr_rsp_t wr_rsp;
	logic                        axi_ar_valid;
	axi_bridge_pkg::ar_chan_t    axi_ar;
	logic                        axi_ar_ready;
	logic                        axi_r_valid;
	axi_bridge_pkg::r_chan_t     axi_r;
	logic                        axi_r_ready;
	logic                        axi_aw_valid;
	axi_bridge_pkg::aw_chan_t    axi_aw;
	logic                        axi_aw_ready;
	logic                        axi_w_valid;
	axi_bridge_pkg::w_chan_t     axi_w;
	logic                        axi_w_ready;
	logic                        axi_b_valid;
	axi_bridge_pkg::b_chan_t     axi_b;
	logic                        axi_b_ready;

	row_t        rows[$];
	row_t        cur_row;      // row being applied
	logic [63:0] shadow [256]; // expected memory contents
	int          errors;
	int          timeouts;

	tb_clk_gen clk_gen_i (.clk(clk), .reset_n(reset_n));

	axi_bridge_top axi_bridge_top_i (
		.clk(clk), .reset_n(reset_n),
		.rd_req_valid_i(rd_req_valid), .rd_req_i(rd_req), .rd_req_ready_o(rd_req_ready),
		.rd_rsp_valid_o(rd_rsp_valid), .rd_rsp_o(rd_rsp),
		.wr_req_valid_i(wr_req_valid), .wr_req_i(wr_req), .wr_req_ready_o(wr_req_ready),
		.wr_done_o(wr_done), .wr_rsp_o(wr_rsp),
		.axi_ar_valid_o(axi_ar_valid), .axi_ar_o(axi_ar), .axi_ar_ready_i(axi_ar_ready),
		.axi_r_valid_i(axi_r_valid), .axi_r_i(axi_r), .axi_r_ready_o(axi_r_ready),
		.axi_aw_valid_o(axi_aw_valid), .axi_aw_o(axi_aw), .axi_aw_ready_i(axi_aw_ready),
		.axi_w_valid_o(axi_w_valid), .axi_w_o(axi_w), .axi_w_ready_i(axi_w_ready),
		.axi_b_valid_i(axi_b_valid), .axi_b_i(axi_b), .axi_b_ready_o(axi_b_ready)
	);

	axi_mem_model mem_i (
		.clk(clk), .reset_n(reset_n), .delay_en_i(delay_en),
		.ar_valid_i(axi_ar_valid), .ar_i(axi_ar), .ar_ready_o(axi_ar_ready),
		.r_valid_o(axi_r_valid), .r_o(axi_r), .r_ready_i(axi_r_ready),
		.aw_valid_i(axi_aw_valid), .aw_i(axi_aw), .aw_ready_o(axi_aw_ready),
		.w_valid_i(axi_w_valid), .w_i(axi_w), .w_ready_o(axi_w_ready),
		.b_valid_o(axi_b_valid), .b_o(axi_b), .b_ready_i(axi_b_ready)
	);

	// same fill rule as the memory model
	function automatic logic [63:0] fill_word(input int n);
		return {32'h1000_0000 + 32'(n), 32'h9e37_79b9 * (32'(n) + 32'd1)};
	endfunction

	// ones on every byte from the offset up to offset plus 2**size
	function automatic logic [63:0] lane_mask(input logic [2:0] off, input logic [1:0] size);
		logic [63:0] m;
		int          lo;
		int          hi;
		m  = '0;
		lo = int'(off);
		hi = lo + (1 << size);
		for (int i = 0; i < 8; i++)
			if (i >= lo && i < hi)
				m[8*i +: 8] = 8'hff;
		return m;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, got);
		end
	endtask

	// builds one row and its expected values from the shadow memory
	task automatic add_row(input logic is_write, input logic [63:0] addr,
			input logic [1:0] size, input logic [7:0] len, input logic [63:0] wdata);
		row_t        r;
		logic [63:0] m;
		int          word;
		int          lo;
		r          = '0;
		r.is_write = is_write;
		r.addr     = addr;
		r.size     = size;
		r.len      = len;
		r.wdata    = wdata;
		m          = lane_mask(addr[2:0], size);
		word       = int'(addr[10:3]);
		lo         = int'(addr[2:0]);
		if (addr >= 64'h800) begin
			r.exp_resp = `AXI_RESP_SLVERR; // read data stays zero
		end else if (is_write) begin
			r.exp_resp = `AXI_RESP_OKAY;
			for (int i = 0; i < 8; i++)
				if (m[8*i])
					shadow[word][8*i +: 8] = wdata[8*(i - lo) +: 8];
		end else begin
			r.exp_resp = `AXI_RESP_OKAY;
			for (int k = 0; k <= int'(len); k++)
				r.exp_data[k] = shadow[word + k] & m;
		end
		rows.push_back(r);
	endtask

	// one copy of the table with the write data xored by flip
	task automatic build_table(input logic [63:0] flip);
		// single reads of each size at several offsets
		add_row(1'b0, 64'h020, 2'd0, 8'd0, 64'd0);
		add_row(1'b0, 64'h02b, 2'd0, 8'd0, 64'd0);
		add_row(1'b0, 64'h037, 2'd0, 8'd0, 64'd0);
		add_row(1'b0, 64'h042, 2'd1, 8'd0, 64'd0);
		add_row(1'b0, 64'h04e, 2'd1, 8'd0, 64'd0);
		add_row(1'b0, 64'h054, 2'd2, 8'd0, 64'd0);
		add_row(1'b0, 64'h058, 2'd2, 8'd0, 64'd0);
		add_row(1'b0, 64'h060, 2'd3, 8'd0, 64'd0);
		// writes with junk in the unused high bytes and a full read back of each
		add_row(1'b1, 64'h105, 2'd0, 8'd0, 64'hffff_ffff_ffff_ffa5 ^ flip);
		add_row(1'b0, 64'h100, 2'd3, 8'd0, 64'd0);
		add_row(1'b1, 64'h10a, 2'd1, 8'd0, 64'h7777_7777_7777_beef ^ flip);
		add_row(1'b0, 64'h108, 2'd3, 8'd0, 64'd0);
		add_row(1'b1, 64'h114, 2'd2, 8'd0, 64'h5555_5555_1234_5678 ^ flip);
		add_row(1'b0, 64'h110, 2'd3, 8'd0, 64'd0);
		add_row(1'b1, 64'h118, 2'd3, 8'd0, 64'h0123_4567_89ab_cdef ^ flip);
		add_row(1'b0, 64'h118, 2'd3, 8'd0, 64'd0);
		// four beat burst
		add_row(1'b0, 64'h200, 2'd3, 8'd3, 64'd0);
		// error region
		add_row(1'b0, 64'h800, 2'd3, 8'd0, 64'd0);
		add_row(1'b0, 64'h9a4, 2'd2, 8'd1, 64'd0);
		add_row(1'b1, 64'h900, 2'd3, 8'd0, 64'hdead_beef_cafe_f00d ^ flip);
	endtask

	// address and write data payloads checked ahead of each handshake edge
	always @(negedge clk) begin
		if (axi_ar_valid && axi_ar_ready) begin
			check_value("axi_ar_o.id", 64'(RD_ID), 64'(axi_ar.id));
			check_value("axi_ar_o.addr", cur_row.addr & ~64'h7, axi_ar.addr);
			check_value("axi_ar_o.len", 64'(cur_row.len), 64'(axi_ar.len));
			check_value("axi_ar_o.size", 64'(cur_row.size), 64'(axi_ar.size));
			check_value("axi_ar_o.burst", 64'(`AXI_BURST_INCR), 64'(axi_ar.burst));
		end
		if (axi_aw_valid && axi_aw_ready) begin
			check_value("axi_aw_o.id", 64'(WR_ID), 64'(axi_aw.id));
			check_value("axi_aw_o.addr", cur_row.addr & ~64'h7, axi_aw.addr);
			check_value("axi_aw_o.len", 64'd0, 64'(axi_aw.len));
			check_value("axi_aw_o.size", 64'(cur_row.size), 64'(axi_aw.size));
			check_value("axi_aw_o.burst", 64'(`AXI_BURST_INCR), 64'(axi_aw.burst));
		end
		if (axi_w_valid && axi_w_ready)
			check_value("axi_w_o.last", 64'd1, 64'(axi_w.last));
	end

	task automatic read_and_check(input row_t r);
		int cnt;
		@(negedge clk);
		rd_req_valid = 1'b1;
		rd_req.id    = RD_ID;
		rd_req.addr  = r.addr;
		rd_req.len   = r.len;
		rd_req.size  = r.size;
		cnt = 0;
		while (!rd_req_ready && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (cnt >= TIMEOUT) begin
			timeouts++;
			$display("timeout: read request at %h was never accepted", r.addr);
			rd_req_valid = 1'b0;
			return;
		end
		@(negedge clk);
		rd_req_valid = 1'b0;
		for (int beat = 0; beat <= int'(r.len); beat++) begin
			cnt = 0;
			while (!rd_rsp_valid && cnt < TIMEOUT) begin
				@(negedge clk);
				cnt++;
			end
			if (cnt >= TIMEOUT) begin
				timeouts++;
				$display("timeout: read at %h returned no beat %0d", r.addr, beat);
				return;
			end
			check_value("rd_rsp_o.data", r.exp_data[beat], rd_rsp.data);
			check_value("rd_rsp_o.resp", 64'(r.exp_resp), 64'(rd_rsp.resp));
			check_value("rd_rsp_o.last", 64'(beat == int'(r.len)), 64'(rd_rsp.last));
			if (beat == int'(r.len))
				check_value("rd_req_ready_o", 64'd1, 64'(rd_req_ready));
			@(negedge clk); // past this one-cycle pulse
		end
	endtask

	task automatic write_and_check(input row_t r);
		int cnt;
		@(negedge clk);
		wr_req_valid = 1'b1;
		wr_req.id    = WR_ID;
		wr_req.addr  = r.addr;
		wr_req.size  = r.size;
		wr_req.data  = r.wdata;
		cnt = 0;
		while (!wr_req_ready && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (cnt >= TIMEOUT) begin
			timeouts++;
			$display("timeout: write request at %h was never accepted", r.addr);
			wr_req_valid = 1'b0;
			return;
		end
		@(negedge clk);
		wr_req_valid = 1'b0;
		cnt = 0;
		while (!wr_done && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (cnt >= TIMEOUT) begin
			timeouts++;
			$display("timeout: write at %h never reported done", r.addr);
			return;
		end
		check_value("wr_rsp_o.resp", 64'(r.exp_resp), 64'(wr_rsp.resp));
	endtask

	initial begin
		int cnt;
		int per_pass;
		errors       = 0;
		timeouts     = 0;
		delay_en     = 1'b0;
		rd_req_valid = 1'b0;
		rd_req       = '0;
		wr_req_valid = 1'b0;
		wr_req       = '0;
		cur_row      = '0;
		for (int n = 0; n < 256; n++)
			shadow[n] = fill_word(n);

		build_table(64'd0);
		per_pass = rows.size();
		// second copy writes new data so a lost write shows up on read back
		build_table(64'h5a5a_5a5a_5a5a_5a5a);

		cnt = 0;
		while (reset_n !== 1'b1 && cnt < TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (cnt >= TIMEOUT) begin
			timeouts++;
			$display("timeout: reset was never released");
		end

		check_value("rd_req_ready_o", 64'd1, 64'(rd_req_ready));
		check_value("wr_req_ready_o", 64'd1, 64'(wr_req_ready));
		check_value("axi_ar_valid_o", 64'd0, 64'(axi_ar_valid));
		check_value("axi_aw_valid_o", 64'd0, 64'(axi_aw_valid));
		check_value("axi_w_valid_o", 64'd0, 64'(axi_w_valid));
		check_value("axi_r_ready_o", 64'd0, 64'(axi_r_ready));
		check_value("axi_b_ready_o", 64'd0, 64'(axi_b_ready));
		check_value("rd_rsp_valid_o", 64'd0, 64'(rd_rsp_valid));
		check_value("wr_done_o", 64'd0, 64'(wr_done));

		// second pass runs under random slave wait states
		for (int pass = 0; pass < 2; pass++) begin
			@(negedge clk);
			delay_en = (pass == 1);
			for (int i = pass * per_pass; i < (pass + 1) * per_pass; i++) begin
				cur_row = rows[i];
				if (rows[i].is_write)
					write_and_check(rows[i]);
				else
					read_and_check(rows[i]);
			end
		end

		$display("errors: %0d  timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* tests/axi_mem_model.sv */
`include "axi_defines.svh"

module axi_mem_model (
	input  logic                     clk,
	input  logic                     reset_n,
	input  logic                     delay_en_i, // random wait states on
	input  logic                     ar_valid_i,
	input  axi_bridge_pkg::ar_chan_t ar_i,
	output logic                     ar_ready_o,
	output logic                     r_valid_o,
	output axi_bridge_pkg::r_chan_t  r_o,
	input  logic                     r_ready_i,
	input  logic                     aw_valid_i,
	input  axi_bridge_pkg::aw_chan_t aw_i,
	output logic                     aw_ready_o,
	input  logic                     w_valid_i,
	input  axi_bridge_pkg::w_chan_t  w_i,
	output logic                     w_ready_o,
	output logic                     b_valid_o,
	output axi_bridge_pkg::b_chan_t  b_o,
	input  logic                     b_ready_i
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [63:0]              mem [256]; // 0x000 to 0x7ff, above is the error region
	logic [31:0]              lfsr;
	logic [1:0]               ar_wait;
	logic [1:0]               r_wait;
	logic [1:0]               aw_wait;
	logic [1:0]               w_wait;
	logic [1:0]               b_wait;
	logic                     rd_busy;
	logic                     rd_err;
	logic [7:0]               rd_word;
	logic [7:0]               rd_left;
	logic [3:0]               rd_id;
	logic                     aw_got;
	logic                     w_got;
	axi_bridge_pkg::aw_chan_t aw_q;
	axi_bridge_pkg::w_chan_t  w_q;

	assign ar_ready_o = !rd_busy && (ar_wait == 2'd0);
	assign aw_ready_o = !aw_got && (aw_wait == 2'd0);
	assign w_ready_o  = !w_got && (w_wait == 2'd0);

	// fill pattern, spreads every bit of the word index
	function automatic logic [63:0] init_word(input int n);
		return {32'h1000_0000 + 32'(n), 32'h9e37_79b9 * (32'(n) + 32'd1)};
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// two LFSR steps, one per bit of the 0 to 3 cycle delay
	task automatic draw_delay(output logic [1:0] d);
		logic b0;
		if (!delay_en_i) begin
			d = 2'd0;
			return;
		end
		lfsr = lfsr_step(lfsr);
		b0   = lfsr[0];
		lfsr = lfsr_step(lfsr);
		d    = {lfsr[0], b0};
	endtask

	always @(posedge clk) begin : slave_seq
		logic [1:0] d;
		if (!reset_n) begin
			for (int n = 0; n < 256; n++)
				mem[n] <= init_word(n);
			lfsr = 32'h8344_13ee;
			ar_wait   <= 2'd0;
			r_wait    <= 2'd0;
			aw_wait   <= 2'd0;
			w_wait    <= 2'd0;
			b_wait    <= 2'd0;
			rd_busy   <= 1'b0;
			r_valid_o <= 1'b0;
			aw_got    <= 1'b0;
			w_got     <= 1'b0;
			b_valid_o <= 1'b0;
		end else begin
			// ready delays only run down while the master waits
			if (ar_valid_i && ar_wait != 2'd0)
				ar_wait <= ar_wait - 2'd1;
			if (aw_valid_i && aw_wait != 2'd0)
				aw_wait <= aw_wait - 2'd1;
			if (w_valid_i && w_wait != 2'd0)
				w_wait <= w_wait - 2'd1;

			if (ar_valid_i && ar_ready_o) begin
				rd_busy <= 1'b1;
				rd_err  <= (ar_i.addr >= 64'h800);
				rd_word <= ar_i.addr[10:3];
				rd_left <= ar_i.len;
				rd_id   <= ar_i.id;
				draw_delay(d);
				ar_wait <= d;
				draw_delay(d);
				r_wait  <= d;
			end

			if (r_valid_o) begin
				if (r_ready_i) begin
					r_valid_o <= 1'b0;
					rd_word   <= rd_word + 8'd1; // next word of the INCR burst
					rd_left   <= rd_left - 8'd1;
					if (r_o.last)
						rd_busy <= 1'b0;
					draw_delay(d);
					r_wait <= d;
				end
			end else if (rd_busy) begin
				if (r_wait != 2'd0) begin
					r_wait <= r_wait - 2'd1;
				end else begin
					r_valid_o <= 1'b1;
					r_o.id    <= rd_id;
					r_o.data  <= rd_err ? 64'd0 : mem[rd_word];
					r_o.resp  <= rd_err ? `AXI_RESP_SLVERR : `AXI_RESP_OKAY;
					r_o.last  <= (rd_left == 8'd0);
				end
			end

			if (aw_valid_i && aw_ready_o) begin
				aw_got <= 1'b1;
				aw_q   <= aw_i;
				draw_delay(d);
				aw_wait <= d;
			end
			if (w_valid_i && w_ready_o) begin
				w_got <= 1'b1;
				w_q   <= w_i;
				draw_delay(d);
				w_wait <= d;
			end

			if (b_valid_o) begin
				if (b_ready_i) begin
					b_valid_o <= 1'b0;
					aw_got    <= 1'b0;
					w_got     <= 1'b0;
					draw_delay(d);
					b_wait <= d;
				end
			end else if (aw_got && w_got) begin
				if (b_wait != 2'd0) begin
					b_wait <= b_wait - 2'd1;
				end else begin
					b_valid_o <= 1'b1;
					b_o.id    <= aw_q.id;
					if (aw_q.addr >= 64'h800) begin
						b_o.resp <= `AXI_RESP_SLVERR; // write dropped
					end else begin
						b_o.resp <= `AXI_RESP_OKAY;
						for (int i = 0; i < 8; i++)
							if (w_q.strb[i])
								mem[aw_q.addr[10:3]][8*i +: 8] <= w_q.data[8*i +: 8];
					end
				end
			end
		end
	end

endmodule

/* tests/tb_clk_gen.sv */
module tb_clk_gen (
	output logic clk,
	output logic reset_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// reset held for 4 cycles, released on a falling edge
	initial begin
		reset_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

/* design/axi_bridge_top.sv */
module axi_bridge_top (
	input  logic                        clk,
	input  logic                        reset_n,
	// core read port
	input  logic                        rd_req_valid_i,
	input  axi_bridge_pkg::cpu_rd_req_t rd_req_i,
	output logic                        rd_req_ready_o,
	output logic                        rd_rsp_valid_o,
	output axi_bridge_pkg::cpu_rd_rsp_t rd_rsp_o,
	// core write port
	input  logic                        wr_req_valid_i,
	input  axi_bridge_pkg::cpu_wr_req_t wr_req_i,
	output logic                        wr_req_ready_o,
	output logic                        wr_done_o,
	output axi_bridge_pkg::cpu_wr_rsp_t wr_rsp_o,
	// AXI master port
	output logic                        axi_ar_valid_o,
	output axi_bridge_pkg::ar_chan_t    axi_ar_o,
	input  logic                        axi_ar_ready_i,
	input  logic                        axi_r_valid_i,
	input  axi_bridge_pkg::r_chan_t     axi_r_i,
	output logic                        axi_r_ready_o,
	output logic                        axi_aw_valid_o,
	output axi_bridge_pkg::aw_chan_t    axi_aw_o,
	input  logic                        axi_aw_ready_i,
	output logic                        axi_w_valid_o,
	output axi_bridge_pkg::w_chan_t     axi_w_o,
	input  logic                        axi_w_ready_i,
	input  logic                        axi_b_valid_i,
	input  axi_bridge_pkg::b_chan_t     axi_b_i,
	output logic                        axi_b_ready_o
);

	// read side, AR and R channels
	axi_rd_master u_rd (
		.clk         (clk),
		.reset_n     (reset_n),
		.req_valid_i (rd_req_valid_i),
		.req_i       (rd_req_i),
		.req_ready_o (rd_req_ready_o),
		.rsp_valid_o (rd_rsp_valid_o),
		.rsp_o       (rd_rsp_o),
		.ar_valid_o  (axi_ar_valid_o),
		.ar_o        (axi_ar_o),
		.ar_ready_i  (axi_ar_ready_i),
		.r_valid_i   (axi_r_valid_i),
		.r_i         (axi_r_i),
		.r_ready_o   (axi_r_ready_o)
	);

	// write side, AW W and B channels
	axi_wr_master u_wr (
		.clk         (clk),
		.reset_n     (reset_n),
		.req_valid_i (wr_req_valid_i),
		.req_i       (wr_req_i),
		.req_ready_o (wr_req_ready_o),
		.done_o      (wr_done_o),
		.rsp_o       (wr_rsp_o),
		.aw_valid_o  (axi_aw_valid_o),
		.aw_o        (axi_aw_o),
		.aw_ready_i  (axi_aw_ready_i),
		.w_valid_o   (axi_w_valid_o),
		.w_o         (axi_w_o),
		.w_ready_i   (axi_w_ready_i),
		.b_valid_i   (axi_b_valid_i),
		.b_i         (axi_b_i),
		.b_ready_o   (axi_b_ready_o)
	);

endmodule

/* design/axi_wr_master.sv */
`include "axi_defines.svh"

module axi_wr_master (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        req_valid_i,
	input  axi_bridge_pkg::cpu_wr_req_t req_i,
	output logic                        req_ready_o,
	output logic                        done_o,
	output axi_bridge_pkg::cpu_wr_rsp_t rsp_o,
	output logic                        aw_valid_o,
	output axi_bridge_pkg::aw_chan_t    aw_o,
	input  logic                        aw_ready_i,
	output logic                        w_valid_o,
	output axi_bridge_pkg::w_chan_t     w_o,
	input  logic                        w_ready_i,
	input  logic                        b_valid_i,
	input  axi_bridge_pkg::b_chan_t     b_i,
	output logic                        b_ready_o
);

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		RESP
	} state_t;

	state_t                       state;
	state_t                       state_nxt;
	logic                         aw_done;  // AW already transferred
	logic                         w_done;   // W already transferred
	logic                         both_done;
	logic [`AXI_OFFSET_WIDTH-1:0] offset;
	logic [`AXI_STRB_WIDTH-1:0]   strb_base;
	logic                         req_hs;
	logic                         aw_hs;
	logic                         w_hs;
	logic                         b_hs;

	assign req_ready_o = (state == IDLE);
	assign aw_valid_o  = (state == SEND) && !aw_done;
	assign w_valid_o   = (state == SEND) && !w_done;
	assign b_ready_o   = (state == RESP);

	assign req_hs = req_valid_i & req_ready_o;
	assign aw_hs  = aw_valid_o & aw_ready_i;
	assign w_hs   = w_valid_o & w_ready_i;
	assign b_hs   = b_valid_i & b_ready_o;

	// AW and W may finish in either order or together
	assign both_done = (aw_done | aw_hs) & (w_done | w_hs);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (req_hs)
					state_nxt = SEND;
			end
			SEND: begin
				if (both_done)
					state_nxt = RESP;
			end
			RESP: begin
				if (b_hs)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else if (req_hs) begin
			aw_done <= 1'b0;
			w_done  <= 1'b0;
		end else begin
			aw_done <= aw_done | aw_hs;
			w_done  <= w_done | w_hs;
		end
	end

	assign offset = req_i.addr[`AXI_OFFSET_WIDTH-1:0];

	always_comb begin
		case (req_i.size)
			2'd0:    strb_base = 8'h01;
			2'd1:    strb_base = 8'h03;
			2'd2:    strb_base = 8'h0f;
			default: strb_base = 8'hff;
		endcase
	end

	// single aligned beat, data moved onto its byte lanes
	always_ff @(posedge clk) begin
		if (req_hs) begin
			aw_o.id    <= req_i.id;
			aw_o.addr  <= {req_i.addr[`AXI_ADDR_WIDTH-1:`AXI_OFFSET_WIDTH],
				{`AXI_OFFSET_WIDTH{1'b0}}};
			aw_o.len   <= '0;
			aw_o.size  <= `AXI_SIZE_WIDTH'(req_i.size);
			aw_o.burst <= `AXI_BURST_INCR;
			w_o.data   <= req_i.data << {offset, 3'b000};
			w_o.strb   <= strb_base << offset;
			w_o.last   <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			done_o <= 1'b0;
		end else begin
			done_o <= b_hs;
		end
	end

	always_ff @(posedge clk) begin
		if (b_hs)
			rsp_o.resp <= b_i.resp;
	end

endmodule

/* design/axi_rd_master.sv */
`include "axi_defines.svh"

module axi_rd_master (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        req_valid_i,
	input  axi_bridge_pkg::cpu_rd_req_t req_i,
	output logic                        req_ready_o,
	output logic                        rsp_valid_o,
	output axi_bridge_pkg::cpu_rd_rsp_t rsp_o,
	output logic                        ar_valid_o,
	output axi_bridge_pkg::ar_chan_t    ar_o,
	input  logic                        ar_ready_i,
	input  logic                        r_valid_i,
	input  axi_bridge_pkg::r_chan_t     r_i,
	output logic                        r_ready_o
);

	typedef enum logic [1:0] {
		IDLE,
		ADDR,
		DATA
	} state_t;

	state_t                      state;
	state_t                      state_nxt;
	axi_bridge_pkg::cpu_rd_req_t req_q;     // held for the whole burst
	logic [`AXI_OFFSET_WIDTH-1:0] offset;
	logic [`AXI_DATA_WIDTH-1:0]  base_mask;
	logic [`AXI_DATA_WIDTH-1:0]  lane_mask;
	logic                        req_hs;
	logic                        ar_hs;
	logic                        r_hs;

	assign req_ready_o = (state == IDLE);
	assign ar_valid_o  = (state == ADDR);
	assign r_ready_o   = (state == DATA);

	assign req_hs = req_valid_i & req_ready_o;
	assign ar_hs  = ar_valid_o & ar_ready_i;
	assign r_hs   = r_valid_i & r_ready_o;

	// AR payload straight from the latched request, stable while valid
	assign ar_o.id    = req_q.id;
	assign ar_o.addr  = {req_q.addr[`AXI_ADDR_WIDTH-1:`AXI_OFFSET_WIDTH],
		{`AXI_OFFSET_WIDTH{1'b0}}}; // aligned down to the word
	assign ar_o.len   = req_q.len;
	assign ar_o.size  = `AXI_SIZE_WIDTH'(req_q.size); // size code maps 1:1
	assign ar_o.burst = `AXI_BURST_INCR;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (req_hs)
					state_nxt = ADDR;
			end
			ADDR: begin
				if (ar_hs)
					state_nxt = DATA;
			end
			DATA: begin
				if (r_hs && r_i.last)
					state_nxt = IDLE;
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (req_hs)
			req_q <= req_i;
	end

	// lane mask, requested width moved up by the byte offset
	assign offset = req_q.addr[`AXI_OFFSET_WIDTH-1:0];

	always_comb begin
		case (req_q.size)
			2'd0:    base_mask = 64'h0000_0000_0000_00ff;
			2'd1:    base_mask = 64'h0000_0000_0000_ffff;
			2'd2:    base_mask = 64'h0000_0000_ffff_ffff;
			default: base_mask = 64'hffff_ffff_ffff_ffff;
		endcase
		lane_mask = base_mask << {offset, 3'b000};
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= r_hs; // one pulse per beat
		end
	end

	always_ff @(posedge clk) begin
		if (r_hs) begin
			rsp_o.data <= r_i.data & lane_mask;
			rsp_o.resp <= r_i.resp;
			rsp_o.last <= r_i.last;
		end
	end

endmodule

/* design/axi_bridge_pkg.sv */
`include "axi_defines.svh"

package axi_bridge_pkg;

	// read address channel
	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]    id;
		logic [`AXI_ADDR_WIDTH-1:0]  addr;
		logic [`AXI_LEN_WIDTH-1:0]   len;
		logic [`AXI_SIZE_WIDTH-1:0]  size;
		logic [`AXI_BURST_WIDTH-1:0] burst;
	} ar_chan_t;

	typedef ar_chan_t aw_chan_t; // write address, same layout as AR

	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [`AXI_RESP_WIDTH-1:0] resp;
		logic                       last;
	} r_chan_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [`AXI_STRB_WIDTH-1:0] strb;
		logic                       last;
	} w_chan_t;

	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_RESP_WIDTH-1:0] resp;
	} b_chan_t;

	// core side read request and returned beat
	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [`AXI_LEN_WIDTH-1:0]  len;
		logic [`CPU_SIZE_WIDTH-1:0] size;
	} cpu_rd_req_t;

	typedef struct packed {
		logic [`AXI_DATA_WIDTH-1:0] data;
		logic [`AXI_RESP_WIDTH-1:0] resp;
		logic                       last;
	} cpu_rd_rsp_t;

	// write data sits in the low bytes, unaligned
	typedef struct packed {
		logic [`AXI_ID_WIDTH-1:0]   id;
		logic [`AXI_ADDR_WIDTH-1:0] addr;
		logic [`CPU_SIZE_WIDTH-1:0] size;
		logic [`AXI_DATA_WIDTH-1:0] data;
	} cpu_wr_req_t;

	typedef struct packed {
		logic [`AXI_RESP_WIDTH-1:0] resp;
	} cpu_wr_rsp_t;

endpackage

/* design/axi_defines.svh */
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// bus widths
`define AXI_DATA_WIDTH   64
`define AXI_ADDR_WIDTH   64
`define AXI_ID_WIDTH     4
`define AXI_LEN_WIDTH    8
`define AXI_SIZE_WIDTH   3
`define AXI_STRB_WIDTH   8
`define AXI_RESP_WIDTH   2
`define AXI_BURST_WIDTH  2

// byte offset inside one data word
`define AXI_OFFSET_WIDTH 3

// core side size code, 0:1B 1:2B 2:4B 3:8B
`define CPU_SIZE_WIDTH   2

// burst and response codes
`define AXI_BURST_INCR   2'b01
`define AXI_RESP_OKAY    2'b00
`define AXI_RESP_SLVERR  2'b10

`endif
